// File: verilog/axi_iso_pkg.sv
////////////////////////////////////////
// Shared widths, pending limit, vector types
// and the isolation state encoding
////////////////////////////////////////

package axi_iso_pkg;

  ////////////////////////////////////////
  // Channel field widths
  ////////////////////////////////////////

  localparam int ID_W   = 4;
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int LEN_W  = 8;
  localparam int RESP_W = 2;

  // Max open transactions per counter
  localparam int PENDING_MAX = 4;
  // Counter must hold 0 up to PENDING_MAX inclusive
  localparam int CNT_W = $clog2(PENDING_MAX + 1);

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  typedef logic [ID_W-1:0]     id_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] strb_t;
  typedef logic [LEN_W-1:0]    len_t;
  typedef logic [RESP_W-1:0]   resp_t;
  typedef logic [CNT_W-1:0]    cnt_t;

  // Per-direction isolation FSM
  typedef enum logic [1:0] {
    NORMAL,
    HOLD,
    DRAIN,
    ISOLATE
  } iso_state_e;

endpackage

// File: verilog/chan_ctl_if.sv
////////////////////////////////////////
// Control bundle for one direction
////////////////////////////////////////

interface chan_ctl_if;

  // Commands from the isolation FSM
  logic addr_pass;
  logic addr_hold;
  logic cut_all;

  // Master-side handshake events from the gate
  logic addr_fire;
  logic data_last_fire;
  logic resp_fire;

  // Counter flags
  logic at_limit;
  logic addr_zero;
  logic w_open;

  modport ctrl (
    output addr_pass, addr_hold, cut_all,
    input  at_limit, addr_zero
  );

  modport gate (
    input  addr_pass, addr_hold, cut_all, w_open,
    output addr_fire, data_last_fire, resp_fire
  );

  modport count (
    input  addr_fire, data_last_fire, resp_fire,
    output at_limit, addr_zero, w_open
  );

endinterface

// File: verilog/pending_tracker.sv
////////////////////////////////////////
// In-flight counters for AW, W and AR
////////////////////////////////////////

module pending_tracker (
  input logic       clk_i,
  input logic       reset_i,
  chan_ctl_if.count wr_cnt,
  chan_ctl_if.count rd_cnt
);

  // Open write bursts, AW accepted and no B yet
  axi_iso_pkg::cnt_t aw_cnt_q;
  // Write bursts still owing their last W beat
  axi_iso_pkg::cnt_t w_cnt_q;
  // Open read bursts, AR accepted and no last R yet
  axi_iso_pkg::cnt_t ar_cnt_q;

  // Up/down step, simultaneous inc and dec cancel out
  function automatic axi_iso_pkg::cnt_t step(
    input axi_iso_pkg::cnt_t cnt,
    input logic              inc,
    input logic              dec
  );
    axi_iso_pkg::cnt_t nxt;
    nxt = cnt;
    if (inc && !dec) begin
      nxt = cnt + axi_iso_pkg::cnt_t'(1);
    end else if (dec && !inc) begin
      nxt = cnt - axi_iso_pkg::cnt_t'(1);
    end
    return nxt;
  endfunction

  ////////////////////////////////////////
  // Counter registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_cnt_q <= '0;
      w_cnt_q  <= '0;
      ar_cnt_q <= '0;
    end else begin
      aw_cnt_q <= step(aw_cnt_q, wr_cnt.addr_fire, wr_cnt.resp_fire);
      w_cnt_q  <= step(w_cnt_q, wr_cnt.addr_fire, wr_cnt.data_last_fire);
      ar_cnt_q <= step(ar_cnt_q, rd_cnt.addr_fire, rd_cnt.data_last_fire);
    end
  end

  ////////////////////////////////////////
  // Flags
  ////////////////////////////////////////

  // Either write counter full holds off AW
  assign wr_cnt.at_limit =
    (aw_cnt_q == axi_iso_pkg::cnt_t'(axi_iso_pkg::PENDING_MAX)) ||
    (w_cnt_q == axi_iso_pkg::cnt_t'(axi_iso_pkg::PENDING_MAX));
  assign rd_cnt.at_limit =
    (ar_cnt_q == axi_iso_pkg::cnt_t'(axi_iso_pkg::PENDING_MAX));

  // B only follows the last W, so AW at zero means W at zero too
  assign wr_cnt.addr_zero = (aw_cnt_q == '0);
  assign rd_cnt.addr_zero = (ar_cnt_q == '0);

  // An AW firing this cycle opens W right away
  assign wr_cnt.w_open = (w_cnt_q != '0) || wr_cnt.addr_fire;
  // No data channel to open on the read side
  assign rd_cnt.w_open = 1'b0;

endmodule

// File: verilog/isolate_ctrl.sv
////////////////////////////////////////
// Write and read isolation FSMs with the
// isolated status output
////////////////////////////////////////

module isolate_ctrl (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     isolate_i,
  chan_ctl_if.ctrl wr_ctl,
  chan_ctl_if.ctrl rd_ctl,
  input  logic     slv_aw_valid_i,
  input  logic     slv_ar_valid_i,
  input  logic     mst_aw_ready_i,
  input  logic     mst_ar_ready_i,
  output logic     isolated_o
);

  axi_iso_pkg::iso_state_e wr_state_q;
  axi_iso_pkg::iso_state_e rd_state_q;
  axi_iso_pkg::iso_state_e wr_state_d;
  axi_iso_pkg::iso_state_e rd_state_d;

  ////////////////////////////////////////
  // Next-state logic, same for both sides
  ////////////////////////////////////////

  function automatic axi_iso_pkg::iso_state_e next_state(
    input axi_iso_pkg::iso_state_e state,
    input logic                    isolate,
    input logic                    at_limit,
    input logic                    addr_zero,
    input logic                    slv_valid,
    input logic                    mst_ready
  );
    axi_iso_pkg::iso_state_e nxt;
    nxt = state;
    case (state)
      axi_iso_pkg::NORMAL: begin
        if (at_limit) begin
          // Address cut, nothing can be left hanging
          if (isolate) begin
            nxt = axi_iso_pkg::DRAIN;
          end
        end else if (slv_valid && !mst_ready) begin
          // Request seen downstream, keep valid up until taken
          nxt = axi_iso_pkg::HOLD;
        end else if (isolate) begin
          nxt = axi_iso_pkg::DRAIN;
        end
      end
      axi_iso_pkg::HOLD: begin
        if (mst_ready) begin
          nxt = isolate ? axi_iso_pkg::DRAIN : axi_iso_pkg::NORMAL;
        end
      end
      axi_iso_pkg::DRAIN: begin
        // Wait for every open burst to finish
        if (addr_zero) begin
          nxt = axi_iso_pkg::ISOLATE;
        end
      end
      axi_iso_pkg::ISOLATE: begin
        if (!isolate) begin
          nxt = axi_iso_pkg::NORMAL;
        end
      end
      default: begin
        nxt = axi_iso_pkg::ISOLATE;
      end
    endcase
    return nxt;
  endfunction

  assign wr_state_d = next_state(wr_state_q, isolate_i, wr_ctl.at_limit,
                                 wr_ctl.addr_zero, slv_aw_valid_i, mst_aw_ready_i);
  assign rd_state_d = next_state(rd_state_q, isolate_i, rd_ctl.at_limit,
                                 rd_ctl.addr_zero, slv_ar_valid_i, mst_ar_ready_i);

  // Both sides come out of reset isolated
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_q <= axi_iso_pkg::ISOLATE;
      rd_state_q <= axi_iso_pkg::ISOLATE;
    end else begin
      wr_state_q <= wr_state_d;
      rd_state_q <= rd_state_d;
    end
  end

  ////////////////////////////////////////
  // Commands to the gates
  ////////////////////////////////////////

  // Write side
  assign wr_ctl.addr_pass = ((wr_state_q == axi_iso_pkg::NORMAL) && !wr_ctl.at_limit) ||
                            (wr_state_q == axi_iso_pkg::HOLD);
  assign wr_ctl.addr_hold = (wr_state_q == axi_iso_pkg::HOLD);
  assign wr_ctl.cut_all   = (wr_state_q == axi_iso_pkg::ISOLATE);

  // Read side
  assign rd_ctl.addr_pass = ((rd_state_q == axi_iso_pkg::NORMAL) && !rd_ctl.at_limit) ||
                            (rd_state_q == axi_iso_pkg::HOLD);
  assign rd_ctl.addr_hold = (rd_state_q == axi_iso_pkg::HOLD);
  assign rd_ctl.cut_all   = (rd_state_q == axi_iso_pkg::ISOLATE);

  // Isolated only once both directions are fully drained
  assign isolated_o = (wr_state_q == axi_iso_pkg::ISOLATE) &&
                      (rd_state_q == axi_iso_pkg::ISOLATE);

endmodule

// File: verilog/write_gate.sv
////////////////////////////////////////
// AW, W and B gating with event reporting
////////////////////////////////////////

module write_gate (
  // AW
  input  logic               slv_aw_valid_i,
  output logic               slv_aw_ready_o,
  input  axi_iso_pkg::id_t   slv_aw_id_i,
  input  axi_iso_pkg::addr_t slv_aw_addr_i,
  input  axi_iso_pkg::len_t  slv_aw_len_i,
  output logic               mst_aw_valid_o,
  input  logic               mst_aw_ready_i,
  output axi_iso_pkg::id_t   mst_aw_id_o,
  output axi_iso_pkg::addr_t mst_aw_addr_o,
  output axi_iso_pkg::len_t  mst_aw_len_o,
  // W
  input  logic               slv_w_valid_i,
  output logic               slv_w_ready_o,
  input  axi_iso_pkg::data_t slv_w_data_i,
  input  axi_iso_pkg::strb_t slv_w_strb_i,
  input  logic               slv_w_last_i,
  output logic               mst_w_valid_o,
  input  logic               mst_w_ready_i,
  output axi_iso_pkg::data_t mst_w_data_o,
  output axi_iso_pkg::strb_t mst_w_strb_o,
  output logic               mst_w_last_o,
  // B
  output logic               slv_b_valid_o,
  input  logic               slv_b_ready_i,
  output axi_iso_pkg::id_t   slv_b_id_o,
  output axi_iso_pkg::resp_t slv_b_resp_o,
  input  logic               mst_b_valid_i,
  output logic               mst_b_ready_o,
  input  axi_iso_pkg::id_t   mst_b_id_i,
  input  axi_iso_pkg::resp_t mst_b_resp_i,
  chan_ctl_if.gate           ctl
);

  // AW, HOLD forces valid while ready stays connected
  assign mst_aw_valid_o = ctl.addr_hold || (ctl.addr_pass && slv_aw_valid_i);
  assign slv_aw_ready_o = ctl.addr_pass && mst_aw_ready_i;
  assign mst_aw_id_o    = ctl.addr_pass ? slv_aw_id_i : '0;
  assign mst_aw_addr_o  = ctl.addr_pass ? slv_aw_addr_i : '0;
  assign mst_aw_len_o   = ctl.addr_pass ? slv_aw_len_i : '0;

  // W flows only for bursts whose AW has gone out
  assign mst_w_valid_o = ctl.w_open && slv_w_valid_i;
  assign slv_w_ready_o = ctl.w_open && mst_w_ready_i;
  assign mst_w_data_o  = ctl.w_open ? slv_w_data_i : '0;
  assign mst_w_strb_o  = ctl.w_open ? slv_w_strb_i : '0;
  assign mst_w_last_o  = ctl.w_open && slv_w_last_i;

  // B cut while isolated
  assign slv_b_valid_o = !ctl.cut_all && mst_b_valid_i;
  assign mst_b_ready_o = !ctl.cut_all && slv_b_ready_i;
  assign slv_b_id_o    = ctl.cut_all ? '0 : mst_b_id_i;
  assign slv_b_resp_o  = ctl.cut_all ? '0 : mst_b_resp_i;

  // Master-side handshakes for the counters
  assign ctl.addr_fire      = mst_aw_valid_o && mst_aw_ready_i;
  assign ctl.data_last_fire = mst_w_valid_o && mst_w_ready_i && mst_w_last_o;
  assign ctl.resp_fire      = mst_b_valid_i && mst_b_ready_o;

endmodule

// File: verilog/read_gate.sv
////////////////////////////////////////
// AR and R gating with event reporting
////////////////////////////////////////

module read_gate (
  // AR
  input  logic               slv_ar_valid_i,
  output logic               slv_ar_ready_o,
  input  axi_iso_pkg::id_t   slv_ar_id_i,
  input  axi_iso_pkg::addr_t slv_ar_addr_i,
  input  axi_iso_pkg::len_t  slv_ar_len_i,
  output logic               mst_ar_valid_o,
  input  logic               mst_ar_ready_i,
  output axi_iso_pkg::id_t   mst_ar_id_o,
  output axi_iso_pkg::addr_t mst_ar_addr_o,
  output axi_iso_pkg::len_t  mst_ar_len_o,
  // R
  output logic               slv_r_valid_o,
  input  logic               slv_r_ready_i,
  output axi_iso_pkg::id_t   slv_r_id_o,
  output axi_iso_pkg::data_t slv_r_data_o,
  output axi_iso_pkg::resp_t slv_r_resp_o,
  output logic               slv_r_last_o,
  input  logic               mst_r_valid_i,
  output logic               mst_r_ready_o,
  input  axi_iso_pkg::id_t   mst_r_id_i,
  input  axi_iso_pkg::data_t mst_r_data_i,
  input  axi_iso_pkg::resp_t mst_r_resp_i,
  input  logic               mst_r_last_i,
  chan_ctl_if.gate           ctl
);

  // AR, same pass and hold rules as AW
  assign mst_ar_valid_o = ctl.addr_hold || (ctl.addr_pass && slv_ar_valid_i);
  assign slv_ar_ready_o = ctl.addr_pass && mst_ar_ready_i;
  assign mst_ar_id_o    = ctl.addr_pass ? slv_ar_id_i : '0;
  assign mst_ar_addr_o  = ctl.addr_pass ? slv_ar_addr_i : '0;
  assign mst_ar_len_o   = ctl.addr_pass ? slv_ar_len_i : '0;

  // R cut while isolated
  assign slv_r_valid_o = !ctl.cut_all && mst_r_valid_i;
  assign mst_r_ready_o = !ctl.cut_all && slv_r_ready_i;
  assign slv_r_id_o    = ctl.cut_all ? '0 : mst_r_id_i;
  assign slv_r_data_o  = ctl.cut_all ? '0 : mst_r_data_i;
  assign slv_r_resp_o  = ctl.cut_all ? '0 : mst_r_resp_i;
  assign slv_r_last_o  = !ctl.cut_all && mst_r_last_i;

  // Events, a read burst closes on its last R beat
  assign ctl.addr_fire      = mst_ar_valid_o && mst_ar_ready_i;
  assign ctl.data_last_fire = mst_r_valid_i && mst_r_ready_o && mst_r_last_i;
  // No B on the read side
  assign ctl.resp_fire      = 1'b0;

endmodule

// File: verilog/axi_isolate.sv
////////////////////////////////////////
// AXI4 isolator top level
////////////////////////////////////////

module axi_isolate (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               isolate_i,
  output logic               isolated_o,
  // Slave side, from the upstream manager
  input  logic               slv_aw_valid_i,
  output logic               slv_aw_ready_o,
  input  axi_iso_pkg::id_t   slv_aw_id_i,
  input  axi_iso_pkg::addr_t slv_aw_addr_i,
  input  axi_iso_pkg::len_t  slv_aw_len_i,
  input  logic               slv_w_valid_i,
  output logic               slv_w_ready_o,
  input  axi_iso_pkg::data_t slv_w_data_i,
  input  axi_iso_pkg::strb_t slv_w_strb_i,
  input  logic               slv_w_last_i,
  output logic               slv_b_valid_o,
  input  logic               slv_b_ready_i,
  output axi_iso_pkg::id_t   slv_b_id_o,
  output axi_iso_pkg::resp_t slv_b_resp_o,
  input  logic               slv_ar_valid_i,
  output logic               slv_ar_ready_o,
  input  axi_iso_pkg::id_t   slv_ar_id_i,
  input  axi_iso_pkg::addr_t slv_ar_addr_i,
  input  axi_iso_pkg::len_t  slv_ar_len_i,
  output logic               slv_r_valid_o,
  input  logic               slv_r_ready_i,
  output axi_iso_pkg::id_t   slv_r_id_o,
  output axi_iso_pkg::data_t slv_r_data_o,
  output axi_iso_pkg::resp_t slv_r_resp_o,
  output logic               slv_r_last_o,
  // Master side, to the downstream subordinate
  output logic               mst_aw_valid_o,
  input  logic               mst_aw_ready_i,
  output axi_iso_pkg::id_t   mst_aw_id_o,
  output axi_iso_pkg::addr_t mst_aw_addr_o,
  output axi_iso_pkg::len_t  mst_aw_len_o,
  output logic               mst_w_valid_o,
  input  logic               mst_w_ready_i,
  output axi_iso_pkg::data_t mst_w_data_o,
  output axi_iso_pkg::strb_t mst_w_strb_o,
  output logic               mst_w_last_o,
  input  logic               mst_b_valid_i,
  output logic               mst_b_ready_o,
  input  axi_iso_pkg::id_t   mst_b_id_i,
  input  axi_iso_pkg::resp_t mst_b_resp_i,
  output logic               mst_ar_valid_o,
  input  logic               mst_ar_ready_i,
  output axi_iso_pkg::id_t   mst_ar_id_o,
  output axi_iso_pkg::addr_t mst_ar_addr_o,
  output axi_iso_pkg::len_t  mst_ar_len_o,
  input  logic               mst_r_valid_i,
  output logic               mst_r_ready_o,
  input  axi_iso_pkg::id_t   mst_r_id_i,
  input  axi_iso_pkg::data_t mst_r_data_i,
  input  axi_iso_pkg::resp_t mst_r_resp_i,
  input  logic               mst_r_last_i
);

  // One control bundle per direction
  chan_ctl_if wr_ctl ();
  chan_ctl_if rd_ctl ();

  ////////////////////////////////////////
  // Control and counting
  ////////////////////////////////////////

  pending_tracker i_tracker (
    .clk_i,
    .reset_i,
    .wr_cnt (wr_ctl),
    .rd_cnt (rd_ctl)
  );

  // Address valids and readys are taken straight from the top ports
  isolate_ctrl i_ctrl (
    .*,
    .wr_ctl (wr_ctl),
    .rd_ctl (rd_ctl)
  );

  ////////////////////////////////////////
  // Channel gates
  ////////////////////////////////////////

  // Port names match the top level one to one
  write_gate i_write_gate (
    .*,
    .ctl (wr_ctl)
  );

  read_gate i_read_gate (
    .*,
    .ctl (rd_ctl)
  );

endmodule

// File: testbench/tb_checker.sv
////////////////////////////////////////
// Checker that watches the DUT ports, keeps
// the expected traffic and counts errors
////////////////////////////////////////

module tb_checker (
  input  logic               clk_i, reset_i, isolate_i, isolated_o,
  input  logic               slv_aw_valid_i, slv_aw_ready_o,
  input  logic               slv_w_valid_i, slv_w_ready_o, slv_w_last_i,
  input  logic               slv_b_valid_o, slv_b_ready_i,
  input  logic               slv_ar_valid_i, slv_ar_ready_o,
  input  logic               slv_r_valid_o, slv_r_ready_i, slv_r_last_o,
  input  axi_iso_pkg::id_t   slv_aw_id_i, slv_b_id_o, slv_ar_id_i, slv_r_id_o, mst_aw_id_o,
  input  axi_iso_pkg::addr_t slv_aw_addr_i, mst_aw_addr_o, slv_ar_addr_i,
  input  axi_iso_pkg::len_t  slv_aw_len_i, mst_aw_len_o, slv_ar_len_i,
  input  axi_iso_pkg::data_t slv_w_data_i, slv_r_data_o, mst_w_data_o,
  input  axi_iso_pkg::strb_t slv_w_strb_i, mst_w_strb_o,
  input  axi_iso_pkg::resp_t slv_b_resp_o, slv_r_resp_o,
  input  logic               mst_aw_valid_o, mst_aw_ready_i,
  input  logic               mst_w_valid_o, mst_w_ready_i, mst_w_last_o,
  input  logic               mst_b_valid_i, mst_b_ready_o,
  input  logic               mst_ar_valid_o, mst_ar_ready_i,
  input  logic               mst_r_valid_i, mst_r_ready_o, mst_r_last_i,
  output int                 err_cnt_o, rd_done_o, wr_done_o
);

  // Accepted AW ids, slave-side W beats and AR requests in arrival order
  axi_iso_pkg::id_t aw_ids[$];
  logic [27:0]      aw_reqs[$];
  logic [36:0]      w_beats[$];
  logic [27:0]      ar_reqs[$];
  logic [27:0]      ar_head;
  logic [36:0]      w_exp;
  int               r_beat;
  // Downstream bursts still open as seen on master-side handshakes
  int               aw_open;
  int               ar_open;
  int               wlast_cnt;
  logic             was_iso;
  logic             was_isolate;

  // Expected read data mixes the address and the beat number
  function automatic axi_iso_pkg::data_t ref_rdata(input axi_iso_pkg::addr_t addr,
                                                   input int beat);
    return {addr ^ 16'hc3a5, 8'(beat), addr[7:0] + 8'(beat * 37)};
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("ERR %s: expected %0h, actual %0h", name, exp_v, act_v);
      err_cnt_o++;
    end
  endtask

  task automatic report_fault(input string what);
    $display("Error at %0t: %s", $time, what);
    err_cnt_o++;
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      err_cnt_o   = 0;
      rd_done_o   = 0;
      wr_done_o   = 0;
      r_beat      = 0;
      aw_open     = 0;
      ar_open     = 0;
      wlast_cnt   = 0;
      was_iso     = 1'b0;
      was_isolate = 1'b0;
      aw_ids.delete();
      aw_reqs.delete();
      w_beats.delete();
      ar_reqs.delete();
    end else begin
      ////////////////////////////////////////
      // Isolation status
      ////////////////////////////////////////
      if (isolated_o) begin
        if (aw_open != 0 || ar_open != 0) begin
          report_fault("isolated_o is high while transactions are still open");
        end
        if (mst_aw_valid_o || mst_w_valid_o || mst_ar_valid_o) begin
          report_fault("a master-side valid is high while isolated");
        end
        if (slv_aw_ready_o || slv_w_ready_o || slv_ar_ready_o) begin
          report_fault("a slave-side ready is high while isolated");
        end
      end
      // Release takes exactly one edge
      if (was_iso && !was_isolate && isolated_o) begin
        report_fault("isolated_o still high one edge after isolate fell");
      end
      was_iso     = isolated_o;
      was_isolate = isolate_i;

      ////////////////////////////////////////
      // Write channels
      ////////////////////////////////////////
      if (slv_aw_valid_i && slv_aw_ready_o) begin
        aw_ids.push_back(slv_aw_id_i);
        aw_reqs.push_back({slv_aw_id_i, slv_aw_addr_i, slv_aw_len_i});
      end
      // Downstream AW carries the upstream request unchanged
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        if (aw_reqs.size() == 0) begin
          report_fault("master-side AW handshake without a slave-side request");
        end else begin
          check_val("aw_fwd", 64'(aw_reqs.pop_front()),
                    64'({mst_aw_id_o, mst_aw_addr_o, mst_aw_len_o}));
        end
      end
      if (slv_w_valid_i && slv_w_ready_o) begin
        w_beats.push_back({slv_w_last_i, slv_w_strb_i, slv_w_data_i});
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (w_beats.size() == 0) begin
          report_fault("master-side W beat without a slave-side beat");
        end else begin
          w_exp = w_beats.pop_front();
          check_val("w_beat", 64'(w_exp), 64'({mst_w_last_o, mst_w_strb_o, mst_w_data_o}));
        end
        if (mst_w_last_o) begin
          wlast_cnt++;
        end
      end
      if (slv_b_valid_o && slv_b_ready_i) begin
        if (aw_ids.size() == 0 || wr_done_o >= wlast_cnt) begin
          report_fault("B returned for a write that was not fully forwarded");
        end else begin
          check_val("b_id", 64'(aw_ids.pop_front()), 64'(slv_b_id_o));
        end
        check_val("b_resp", 64'(0), 64'(slv_b_resp_o));
        wr_done_o++;
      end

      ////////////////////////////////////////
      // Read channels
      ////////////////////////////////////////
      if (slv_ar_valid_i && slv_ar_ready_o) begin
        ar_reqs.push_back({slv_ar_id_i, slv_ar_addr_i, slv_ar_len_i});
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        if (ar_reqs.size() == 0) begin
          report_fault("R beat returned with no read open");
        end else begin
          ar_head = ar_reqs[0];
          check_val("r_id", 64'(ar_head[27:24]), 64'(slv_r_id_o));
          check_val("r_data", 64'(ref_rdata(ar_head[23:8], r_beat)), 64'(slv_r_data_o));
          check_val("r_resp", 64'(0), 64'(slv_r_resp_o));
          check_val("r_last", 64'(r_beat == int'(ar_head[7:0])), 64'(slv_r_last_o));
          if (slv_r_last_o) begin
            void'(ar_reqs.pop_front());
            r_beat = 0;
            rd_done_o++;
          end else begin
            r_beat++;
          end
        end
      end

      // Pending limit downstream
      aw_open = aw_open + int'(mst_aw_valid_o && mst_aw_ready_i)
                        - int'(mst_b_valid_i && mst_b_ready_o);
      ar_open = ar_open + int'(mst_ar_valid_o && mst_ar_ready_i)
                        - int'(mst_r_valid_i && mst_r_ready_o && mst_r_last_i);
      if (aw_open > axi_iso_pkg::PENDING_MAX) begin
        report_fault("more writes open downstream than the pending limit");
      end
      if (ar_open > axi_iso_pkg::PENDING_MAX) begin
        report_fault("more reads open downstream than the pending limit");
      end
    end
  end

endmodule

// File: testbench/tb_top.sv
////////////////////////////////////////
// Testbench top with clock, reset, manager,
// subordinate model and watchdog
////////////////////////////////////////

module tb_top;

  localparam int N_PASS  = 20;
  localparam int N_LIMIT = 8;
  localparam int N_DRAIN = 6;
  // Reads plus writes over all phases
  localparam int N_TOTAL   = 2 * (N_PASS + N_LIMIT + N_DRAIN);
  localparam int WD_CYCLES = N_TOTAL * 40 + 2000;

  logic clk_i, reset_i, isolate_i, isolated_o;
  // Slave side
  logic slv_aw_valid_i, slv_aw_ready_o, slv_w_valid_i, slv_w_ready_o, slv_w_last_i;
  logic slv_b_valid_o, slv_b_ready_i, slv_ar_valid_i, slv_ar_ready_o;
  logic slv_r_valid_o, slv_r_ready_i, slv_r_last_o;
  axi_iso_pkg::id_t   slv_aw_id_i, slv_b_id_o, slv_ar_id_i, slv_r_id_o;
  axi_iso_pkg::addr_t slv_aw_addr_i, slv_ar_addr_i;
  axi_iso_pkg::len_t  slv_aw_len_i, slv_ar_len_i;
  axi_iso_pkg::data_t slv_w_data_i, slv_r_data_o;
  axi_iso_pkg::strb_t slv_w_strb_i;
  axi_iso_pkg::resp_t slv_b_resp_o, slv_r_resp_o;
  // Master side
  logic mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_ready_i, mst_w_last_o;
  logic mst_b_valid_i, mst_b_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  logic mst_r_valid_i, mst_r_ready_o, mst_r_last_i;
  axi_iso_pkg::id_t   mst_aw_id_o, mst_b_id_i, mst_ar_id_o, mst_r_id_i;
  axi_iso_pkg::addr_t mst_aw_addr_o, mst_ar_addr_o;
  axi_iso_pkg::len_t  mst_aw_len_o, mst_ar_len_o;
  axi_iso_pkg::data_t mst_w_data_o, mst_r_data_i;
  axi_iso_pkg::strb_t mst_w_strb_o;
  axi_iso_pkg::resp_t mst_b_resp_i, mst_r_resp_i;

  int          err_cnt, rd_done, wr_done;
  // Subordinate stops answering while set
  logic        withhold;
  logic [31:0] lfsr_q = 32'h68b4b2b1;

  // Subordinate state with handshakes captured on the rising edge
  axi_iso_pkg::id_t sub_aw_q[$];
  axi_iso_pkg::id_t sub_b_q[$];
  logic [27:0]      sub_ar_q[$];
  logic [27:0]      sub_head;
  int               sub_beat;
  logic             cap_rst, cap_aw, cap_w_last, cap_b, cap_ar, cap_r;
  axi_iso_pkg::id_t cap_aw_id;
  logic [27:0]      cap_ar_req;

  axi_isolate axi_isolate_i (.*);

  tb_checker u_chk (
    .*,
    .err_cnt_o (err_cnt),
    .rd_done_o (rd_done),
    .wr_done_o (wr_done)
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // Upstream manager
  ////////////////////////////////////////

  // AW then its W beats for one burst after another
  task automatic issue_writes(input int n);
    axi_iso_pkg::len_t len;
    for (int i = 0; i < n; i++) begin
      repeat (int'(rand_bits(2))) @(negedge clk_i);
      len            = axi_iso_pkg::len_t'(rand_bits(2));
      slv_aw_valid_i = 1'b1;
      slv_aw_id_i    = axi_iso_pkg::id_t'(rand_bits(4));
      slv_aw_addr_i  = axi_iso_pkg::addr_t'(rand_bits(16));
      slv_aw_len_i   = len;
      @(posedge clk_i);
      while (!slv_aw_ready_o) @(posedge clk_i);
      @(negedge clk_i);
      slv_aw_valid_i = 1'b0;
      for (int b = 0; b <= int'(len); b++) begin
        slv_w_valid_i = 1'b1;
        slv_w_data_i  = rand_bits(32);
        slv_w_strb_i  = axi_iso_pkg::strb_t'(rand_bits(4));
        slv_w_last_i  = (b == int'(len));
        @(posedge clk_i);
        while (!slv_w_ready_o) @(posedge clk_i);
        @(negedge clk_i);
        slv_w_valid_i = 1'b0;
      end
    end
  endtask

  // AR requests only while the ready process takes the R beats
  task automatic issue_reads(input int n);
    for (int i = 0; i < n; i++) begin
      repeat (int'(rand_bits(2))) @(negedge clk_i);
      slv_ar_valid_i = 1'b1;
      slv_ar_id_i    = axi_iso_pkg::id_t'(rand_bits(4));
      slv_ar_addr_i  = axi_iso_pkg::addr_t'(rand_bits(16));
      slv_ar_len_i   = axi_iso_pkg::len_t'(rand_bits(2));
      @(posedge clk_i);
      while (!slv_ar_ready_o) @(posedge clk_i);
      @(negedge clk_i);
      slv_ar_valid_i = 1'b0;
    end
  endtask

  task automatic wait_done(input int n);
    while (rd_done < n || wr_done < n) @(negedge clk_i);
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin : resp_ready
    slv_b_ready_i = 1'b0;
    slv_r_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      slv_b_ready_i = (rand_bits(2) != 0);
      slv_r_ready_i = (rand_bits(2) != 0);
    end
  end

  ////////////////////////////////////////
  // Downstream subordinate answering in order
  ////////////////////////////////////////

  initial begin : subordinate
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    mst_ar_ready_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = 1'b0;
    sub_beat       = 0;
    forever begin
      @(posedge clk_i);
      cap_rst    = reset_i;
      cap_aw     = mst_aw_valid_o && mst_aw_ready_i;
      cap_aw_id  = mst_aw_id_o;
      cap_w_last = mst_w_valid_o && mst_w_ready_i && mst_w_last_o;
      cap_b      = mst_b_valid_i && mst_b_ready_o;
      cap_ar     = mst_ar_valid_o && mst_ar_ready_i;
      cap_ar_req = {mst_ar_id_o, mst_ar_addr_o, mst_ar_len_o};
      cap_r      = mst_r_valid_i && mst_r_ready_o;
      @(negedge clk_i);
      if (!cap_rst) begin
        if (cap_aw) begin
          sub_aw_q.push_back(cap_aw_id);
        end
        // B id follows the AW whose burst just ended
        if (cap_w_last) begin
          sub_b_q.push_back(sub_aw_q.pop_front());
        end
        if (cap_b) begin
          void'(sub_b_q.pop_front());
          mst_b_valid_i = 1'b0;
        end
        if (cap_ar) begin
          sub_ar_q.push_back(cap_ar_req);
        end
        if (cap_r) begin
          mst_r_valid_i = 1'b0;
          if (mst_r_last_i) begin
            void'(sub_ar_q.pop_front());
            sub_beat = 0;
          end else begin
            sub_beat++;
          end
        end
        if (!mst_b_valid_i && sub_b_q.size() > 0 && !withhold && rand_bits(1) != 0) begin
          mst_b_valid_i = 1'b1;
          mst_b_id_i    = sub_b_q[0];
          mst_b_resp_i  = '0;
        end
        if (!mst_r_valid_i && sub_ar_q.size() > 0 && !withhold && rand_bits(1) != 0) begin
          sub_head      = sub_ar_q[0];
          mst_r_valid_i = 1'b1;
          mst_r_id_i    = sub_head[27:24];
          mst_r_data_i  = u_chk.ref_rdata(sub_head[23:8], sub_beat);
          mst_r_last_i  = (sub_beat == int'(sub_head[7:0]));
        end
      end
      mst_aw_ready_i = (rand_bits(1) != 0);
      mst_w_ready_i  = (rand_bits(1) != 0);
      mst_ar_ready_i = (rand_bits(1) != 0);
    end
  end

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge clk_i);
    $display("Timeout: the tests did not complete within %0d cycles", WD_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : main
    reset_i        = 1'b1;
    isolate_i      = 1'b0;
    withhold       = 1'b0;
    slv_aw_valid_i = 1'b0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_w_valid_i  = 1'b0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_last_i   = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // Pass-through traffic
    fork
      issue_writes(N_PASS);
      issue_reads(N_PASS);
    join
    wait_done(N_PASS);

    // Pending limit with the subordinate silent
    withhold = 1'b1;
    fork
      issue_writes(N_LIMIT);
      issue_reads(N_LIMIT);
      begin
        repeat (60) @(negedge clk_i);
        withhold = 1'b0;
      end
    join
    wait_done(N_PASS + N_LIMIT);

    // Isolate with bursts open and release afterwards
    withhold = 1'b1;
    fork
      issue_writes(N_DRAIN);
      issue_reads(N_DRAIN);
      begin
        // Raise isolate once a write and a read are open downstream
        while (u_chk.aw_open == 0 || u_chk.ar_open == 0) @(negedge clk_i);
        isolate_i = 1'b1;
        repeat (10) @(negedge clk_i);
        withhold = 1'b0;
        @(posedge clk_i);
        while (!isolated_o) @(posedge clk_i);
        repeat (20) @(negedge clk_i);
        isolate_i = 1'b0;
      end
    join
    wait_done(N_PASS + N_LIMIT + N_DRAIN);
    repeat (5) @(negedge clk_i);

    $display("Summary: %0d errors, %0d reads and %0d writes completed",
             err_cnt, rd_done, wr_done);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
verilog/axi_iso_pkg.sv
verilog/chan_ctl_if.sv
verilog/pending_tracker.sv
verilog/isolate_ctrl.sv
verilog/write_gate.sv
verilog/read_gate.sv
verilog/axi_isolate.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the isolator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_top -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

# Fails the script unless the pass line is present
echo "$out" | grep -q "^TB PASSED$"
